// File: src/host_pkg.sv
/* Shared widths, vector types, AXI-lite bus structs, FSM state enum
   and register map constants for the host domain */
`default_nettype none

package host_pkg;

  typedef logic [31:0] cfg_addr_t;
  typedef logic [31:0] cfg_data_t;
  typedef logic [1:0]  cfg_resp_t;
  typedef logic [2:0]  reg_idx_t;
  typedef logic [31:0] counter_t;

  localparam cfg_resp_t RespOkay   = 2'b00;
  localparam cfg_resp_t RespSlvErr = 2'b10;

  localparam int unsigned NumCounters = 4;

  // Filler word for unmapped reads
  localparam cfg_data_t UnmappedData = 32'hdeadf000;

  localparam reg_idx_t CntBaseIdx = 3'd0;
  localparam reg_idx_t ThrBaseIdx = 3'd4;

  // Last member is bit 0, so read_hit sits at counter index 0
  typedef struct packed {
    logic write_miss;
    logic write_hit;
    logic read_miss;
    logic read_hit;
  } llc_events_t;

  typedef struct packed {
    logic      aw_valid;
    cfg_addr_t aw_addr;
    logic      w_valid;
    cfg_data_t w_data;
    logic      b_ready;
    logic      ar_valid;
    cfg_addr_t ar_addr;
    logic      r_ready;
  } lite_req_t;

  typedef struct packed {
    logic      aw_ready;
    logic      w_ready;
    logic      b_valid;
    cfg_resp_t b_resp;
    logic      ar_ready;
    logic      r_valid;
    cfg_resp_t r_resp;
    cfg_data_t r_data;
  } lite_resp_t;

  typedef enum logic [1:0] {
    CFG_IDLE,
    CFG_RDATA,
    CFG_BRESP
  } cfg_state_e;

endpackage

`default_nettype wire

// File: src/cfg_lite_fsm.sv
/* AXI-lite slave handshake FSM, one access at a time with reads first,
   issuing single-cycle register strobes */
`timescale 1ns/1ps
`default_nettype none

module cfg_lite_fsm import host_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  lite_req_t  lite_req_i,
  output lite_resp_t lite_resp_o,
  output logic       rd_en_o,
  output logic       wr_en_o,
  output cfg_addr_t  addr_o,
  output cfg_data_t  wdata_o,
  input  cfg_data_t  rdata_i,
  input  logic       mapped_i
);

  cfg_state_e state_q, state_d;

  logic      idle;
  logic      rd_accept;
  logic      wr_accept;
  cfg_data_t r_data_q;
  cfg_resp_t r_resp_q;
  cfg_resp_t b_resp_q;

  assign idle = (state_q == CFG_IDLE);

  // Read wins when both channels present a request
  assign rd_accept = idle && lite_req_i.ar_valid;
  assign wr_accept = idle && !lite_req_i.ar_valid &&
                     lite_req_i.aw_valid && lite_req_i.w_valid;

  assign rd_en_o = rd_accept;
  assign wr_en_o = wr_accept;
  assign addr_o  = rd_accept ? lite_req_i.ar_addr : lite_req_i.aw_addr;
  assign wdata_o = lite_req_i.w_data;

  always_comb begin
    state_d = state_q;
    case (state_q)
      CFG_IDLE: begin
        if (rd_accept) begin
          state_d = CFG_RDATA;
        end else if (wr_accept) begin
          state_d = CFG_BRESP;
        end
      end
      CFG_RDATA: begin
        if (lite_req_i.r_ready) state_d = CFG_IDLE;
      end
      CFG_BRESP: begin
        if (lite_req_i.b_ready) state_d = CFG_IDLE;
      end
      default: state_d = CFG_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= CFG_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Response payload, held until the master takes it
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      r_data_q <= rdata_i;
      r_resp_q <= mapped_i ? RespOkay : RespSlvErr;
    end
    if (wr_accept) begin
      b_resp_q <= mapped_i ? RespOkay : RespSlvErr;
    end
  end

  always_comb begin
    lite_resp_o          = '0;
    lite_resp_o.ar_ready = idle;
    // AW and W only move as a pair
    lite_resp_o.aw_ready = idle && !lite_req_i.ar_valid && lite_req_i.w_valid;
    lite_resp_o.w_ready  = idle && !lite_req_i.ar_valid && lite_req_i.aw_valid;
    lite_resp_o.r_valid  = (state_q == CFG_RDATA);
    lite_resp_o.r_data   = r_data_q;
    lite_resp_o.r_resp   = r_resp_q;
    lite_resp_o.b_valid  = (state_q == CFG_BRESP);
    lite_resp_o.b_resp   = b_resp_q;
  end

endmodule

`default_nettype wire

// File: src/pmu_event_counters.sv
/* Four saturating cache event counters with per-counter clear */
`timescale 1ns/1ps
`default_nettype none

module pmu_event_counters import host_pkg::*; (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  llc_events_t                      events_i,
  input  logic     [NumCounters-1:0]       clear_i,
  output counter_t [NumCounters-1:0]       count_o
);

  logic     [NumCounters-1:0] event_vec;
  logic     [NumCounters-1:0] at_max;
  counter_t [NumCounters-1:0] cnt_q;

  // Struct bit k is the strobe for counter k
  assign event_vec = events_i;

  always_comb begin
    for (int k = 0; k < NumCounters; k++) begin
      at_max[k] = &cnt_q[k];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int k = 0; k < NumCounters; k++) begin
        // Clear beats a same-cycle event
        if (clear_i[k]) begin
          cnt_q[k] <= '0;
        end else if (event_vec[k] && !at_max[k]) begin
          cnt_q[k] <= cnt_q[k] + counter_t'(1);
        end
      end
    end
  end

  assign count_o = cnt_q;

endmodule

`default_nettype wire

// File: src/pmu_cfg_regs.sv
/* Monitor register file: address decode, threshold registers, counter
   clear pulses, read mux and threshold interrupts */
`timescale 1ns/1ps
`default_nettype none

module pmu_cfg_regs import host_pkg::*; (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         rd_en_i,
  input  logic                         wr_en_i,
  input  cfg_addr_t                    addr_i,
  input  cfg_data_t                    wdata_i,
  output cfg_data_t                    rdata_o,
  output logic                         mapped_o,
  input  counter_t [NumCounters-1:0]   count_i,
  output logic     [NumCounters-1:0]   clear_o,
  output logic     [NumCounters-1:0]   pmu_irq_o
);

  reg_idx_t reg_idx;
  reg_idx_t cnt_off;
  reg_idx_t thr_off;
  logic     mapped;
  logic     is_thr;
  logic     thr_we;

  counter_t [NumCounters-1:0] thr_q;

  // Word index from bits 4:2, everything above must be zero
  assign reg_idx  = addr_i[4:2];
  assign mapped   = (addr_i[31:5] == '0);
  assign mapped_o = mapped;

  assign is_thr  = (reg_idx >= ThrBaseIdx);
  assign cnt_off = reg_idx - CntBaseIdx;
  assign thr_off = reg_idx - ThrBaseIdx;
  assign thr_we  = wr_en_i && mapped && is_thr;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      thr_q <= '0;
    end else if (thr_we) begin
      thr_q[thr_off[1:0]] <= wdata_i;
    end
  end

  // Counter writes only clear, the data is ignored
  always_comb begin
    clear_o = '0;
    if (wr_en_i && mapped && !is_thr) begin
      clear_o[cnt_off[1:0]] = 1'b1;
    end
  end

  always_comb begin
    rdata_o = '0;
    if (rd_en_i) begin
      if (!mapped) begin
        rdata_o = UnmappedData;
      end else if (is_thr) begin
        rdata_o = thr_q[thr_off[1:0]];
      end else begin
        rdata_o = count_i[cnt_off[1:0]];
      end
    end
  end

  // Zero threshold disables the interrupt
  always_comb begin
    for (int k = 0; k < NumCounters; k++) begin
      pmu_irq_o[k] = (thr_q[k] != '0) && (count_i[k] >= thr_q[k]);
    end
  end

endmodule

`default_nettype wire

// File: src/dma_evt_rx.sv
/* Receiver for the toggle-coded cluster DMA event: level acknowledge
   and one pulse per toggle */
`timescale 1ns/1ps
`default_nettype none

module dma_evt_rx (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  output logic valid_o,
  output logic ack_o
);

  logic [1:0] sync_q;
  logic       last_q;
  logic       pulse_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q  <= '0;
      last_q  <= 1'b0;
      pulse_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], valid_i};
      last_q  <= sync_q[1];
      // Edge of the synchronized level
      pulse_q <= sync_q[1] ^ last_q;
    end
  end

  // Acknowledge echoes the synchronized toggle back to the cluster
  assign ack_o   = sync_q[1];
  assign valid_o = pulse_q;

endmodule

`default_nettype wire

// File: src/host_domain.sv
/* Host domain top: AXI-lite config responder, performance monitor
   and cluster DMA event receiver */
`timescale 1ns/1ps
`default_nettype none

module host_domain import host_pkg::*; (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  lite_req_t              cfg_req_i,
  output lite_resp_t             cfg_resp_o,
  input  llc_events_t            llc_events_i,
  output logic [NumCounters-1:0] pmu_irq_o,
  input  logic                   dma_pe_evt_valid_i,
  output logic                   dma_pe_evt_o,
  output logic                   dma_pe_evt_ack_o
);

  logic      reg_rd_en;
  logic      reg_wr_en;
  cfg_addr_t reg_addr;
  cfg_data_t reg_wdata;
  cfg_data_t reg_rdata;
  logic      reg_mapped;

  logic     [NumCounters-1:0] cnt_clear;
  counter_t [NumCounters-1:0] cnt_value;

  cfg_lite_fsm i_cfg_lite_fsm (
    .clk_i       ( clk_i      ),
    .arst_n_i    ( arst_n_i   ),
    .lite_req_i  ( cfg_req_i  ),
    .lite_resp_o ( cfg_resp_o ),
    .rd_en_o     ( reg_rd_en  ),
    .wr_en_o     ( reg_wr_en  ),
    .addr_o      ( reg_addr   ),
    .wdata_o     ( reg_wdata  ),
    .rdata_i     ( reg_rdata  ),
    .mapped_i    ( reg_mapped )
  );

  pmu_cfg_regs i_pmu_cfg_regs (
    .clk_i     ( clk_i      ),
    .arst_n_i  ( arst_n_i   ),
    .rd_en_i   ( reg_rd_en  ),
    .wr_en_i   ( reg_wr_en  ),
    .addr_i    ( reg_addr   ),
    .wdata_i   ( reg_wdata  ),
    .rdata_o   ( reg_rdata  ),
    .mapped_o  ( reg_mapped ),
    .count_i   ( cnt_value  ),
    .clear_o   ( cnt_clear  ),
    .pmu_irq_o ( pmu_irq_o  )
  );

  pmu_event_counters i_pmu_event_counters (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .events_i ( llc_events_i ),
    .clear_i  ( cnt_clear    ),
    .count_o  ( cnt_value    )
  );

  dma_evt_rx i_dma_evt_rx (
    .clk_i    ( clk_i              ),
    .arst_n_i ( arst_n_i           ),
    .valid_i  ( dma_pe_evt_valid_i ),
    .valid_o  ( dma_pe_evt_o       ),
    .ack_o    ( dma_pe_evt_ack_o   )
  );

endmodule

`default_nettype wire

// File: testbench/host_domain_sva.sv
/* Bound assertions on the AXI-lite handshake and the DMA event pulse */
`timescale 1ns/1ps
`default_nettype none

module host_domain_sva import host_pkg::*; (
  input logic       clk_i,
  input logic       arst_n_i,
  input lite_req_t  req_i,
  input lite_resp_t resp_i,
  input logic       evt_i
);

  // Read response holds while the master stalls
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_i.r_valid && !req_i.r_ready |=>
      resp_i.r_valid && $stable(resp_i.r_data) && $stable(resp_i.r_resp))
    else $error("read response changed under back-pressure");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_i.b_valid && !req_i.b_ready |=> resp_i.b_valid && $stable(resp_i.b_resp))
    else $error("write response changed under back-pressure");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(resp_i.r_valid && resp_i.b_valid))
    else $error("read and write responses valid together");

  // Nothing accepted while a response is pending
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_i.r_valid || resp_i.b_valid |-> !resp_i.ar_ready && !resp_i.aw_ready)
    else $error("request accepted with a response pending");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    evt_i |=> !evt_i)
    else $error("DMA event pulse longer than one cycle");

endmodule

bind host_domain host_domain_sva i_host_domain_sva (
  .clk_i    ( clk_i        ),
  .arst_n_i ( arst_n_i     ),
  .req_i    ( cfg_req_i    ),
  .resp_i   ( cfg_resp_o   ),
  .evt_i    ( dma_pe_evt_o )
);

`default_nettype wire

// File: testbench/tb_host_domain.sv
/* Host domain testbench with clock, reset, AXI-lite bus tasks, event
   reference counts, checks and watchdog */
`timescale 1ns/1ps
`default_nettype none

module tb_host_domain import host_pkg::*; ();

  logic                   clk;
  logic                   arst_n;
  lite_req_t              cfg_req;
  lite_resp_t             cfg_resp;
  llc_events_t            llc_events;
  logic [NumCounters-1:0] pmu_irq;
  logic                   dma_evt_valid;
  logic                   dma_evt;
  logic                   dma_evt_ack;

  integer      seed;
  int unsigned ref_cnt [NumCounters];
  cfg_data_t   thr_val [NumCounters];
  int unsigned pulse_cnt = 0;

  host_domain UUT (
    .clk_i              ( clk           ),
    .arst_n_i           ( arst_n        ),
    .cfg_req_i          ( cfg_req       ),
    .cfg_resp_o         ( cfg_resp      ),
    .llc_events_i       ( llc_events    ),
    .pmu_irq_o          ( pmu_irq       ),
    .dma_pe_evt_valid_i ( dma_evt_valid ),
    .dma_pe_evt_o       ( dma_evt       ),
    .dma_pe_evt_ack_o   ( dma_evt_ack   )
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(negedge clk) begin
    if (dma_evt) pulse_cnt <= pulse_cnt + 1;
  end

  // Several times the full test length
  initial begin
    #20000;
    $display("Timeout: the test did not finish within 20000 ns");
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic rand_bit();
    integer r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic cfg_addr_t reg_addr(input int unsigned idx);
    return cfg_addr_t'(idx << 2);
  endfunction

  task automatic check_value(input cfg_data_t actual, input cfg_data_t expected,
                             input string what);
    assert (actual === expected) else begin
      $display("CHECK FAILED at %0d ns: %s, got 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at the first error");
    end
  endtask

  // Random ready per cycle gives back-pressure stretches
  task automatic lite_read(input cfg_addr_t addr, output cfg_data_t data,
                           output cfg_resp_t resp);
    logic done;
    cfg_req.ar_valid = 1'b1;
    cfg_req.ar_addr  = addr;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = cfg_resp.ar_ready;
      next_cycle();
    end
    cfg_req.ar_valid = 1'b0;
    done = 1'b0;
    while (!done) begin
      cfg_req.r_ready = rand_bit();
      @(negedge clk);
      if (cfg_resp.r_valid && cfg_req.r_ready) begin
        data = cfg_resp.r_data;
        resp = cfg_resp.r_resp;
        done = 1'b1;
      end
      next_cycle();
    end
    cfg_req.r_ready = 1'b0;
  endtask

  task automatic lite_write(input cfg_addr_t addr, input cfg_data_t data,
                            output cfg_resp_t resp);
    logic done;
    cfg_req.aw_valid = 1'b1;
    cfg_req.aw_addr  = addr;
    cfg_req.w_valid  = 1'b1;
    cfg_req.w_data   = data;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = cfg_resp.aw_ready && cfg_resp.w_ready;
      next_cycle();
    end
    cfg_req.aw_valid = 1'b0;
    cfg_req.w_valid  = 1'b0;
    done = 1'b0;
    while (!done) begin
      cfg_req.b_ready = rand_bit();
      @(negedge clk);
      if (cfg_resp.b_valid && cfg_req.b_ready) begin
        resp = cfg_resp.b_resp;
        done = 1'b1;
      end
      next_cycle();
    end
    cfg_req.b_ready = 1'b0;
  endtask

  task automatic read_expect(input cfg_addr_t addr, input cfg_data_t exp_data,
                             input cfg_resp_t exp_resp, input string what);
    cfg_data_t data;
    cfg_resp_t resp;
    lite_read(addr, data, resp);
    check_value(data, exp_data, {what, " data"});
    check_value(cfg_data_t'(resp), cfg_data_t'(exp_resp), {what, " response"});
  endtask

  task automatic write_expect(input cfg_addr_t addr, input cfg_data_t data,
                              input cfg_resp_t exp_resp, input string what);
    cfg_resp_t resp;
    lite_write(addr, data, resp);
    check_value(cfg_data_t'(resp), cfg_data_t'(exp_resp), {what, " response"});
  endtask

  initial begin
    int unsigned k;
    int unsigned i;
    int unsigned base;
    integer      rnd;
    seed          = 90;
    arst_n        = 1'b0;
    cfg_req       = '0;
    llc_events    = '0;
    dma_evt_valid = 1'b0;
    for (k = 0; k < NumCounters; k++) ref_cnt[k] = 0;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    next_cycle();

    check_value(cfg_data_t'(cfg_resp.r_valid), 32'd0, "r_valid after reset");
    check_value(cfg_data_t'(cfg_resp.b_valid), 32'd0, "b_valid after reset");
    check_value(cfg_data_t'(pmu_irq), 32'd0, "interrupts after reset");
    check_value(cfg_data_t'(dma_evt), 32'd0, "DMA event pulse after reset");
    check_value(cfg_data_t'(dma_evt_ack), 32'd0, "DMA event ack after reset");
    for (k = 0; k < 8; k++) begin
      read_expect(reg_addr(k), 32'd0, RespOkay, $sformatf("register %0d after reset", k));
    end

    // Threshold write and readback followed by unmapped accesses
    for (k = 0; k < NumCounters; k++) begin
      thr_val[k] = $random(seed);
      write_expect(reg_addr(ThrBaseIdx + k), thr_val[k], RespOkay, "threshold write");
    end
    for (k = 0; k < NumCounters; k++) begin
      read_expect(reg_addr(ThrBaseIdx + k), thr_val[k], RespOkay, "threshold readback");
    end
    read_expect(32'h0000_0100, UnmappedData, RespSlvErr, "unmapped read");
    write_expect(32'h0000_0110, 32'h1234_5678, RespSlvErr, "unmapped write");
    for (k = 0; k < NumCounters; k++) begin
      read_expect(reg_addr(ThrBaseIdx + k), thr_val[k], RespOkay, "threshold after unmapped");
    end

    for (i = 0; i < 200; i++) begin
      rnd        = $random(seed);
      llc_events = rnd[3:0];
      for (k = 0; k < NumCounters; k++) begin
        if (llc_events[k]) ref_cnt[k]++;
      end
      next_cycle();
    end
    llc_events = '0;
    next_cycle();
    for (k = 0; k < NumCounters; k++) begin
      read_expect(reg_addr(k), ref_cnt[k], RespOkay, $sformatf("counter %0d total", k));
    end

    // Interrupt at threshold 5 and clear by a counter write
    for (k = 0; k < NumCounters; k++) begin
      write_expect(reg_addr(k), 32'd0, RespOkay, "counter clear");
      write_expect(reg_addr(ThrBaseIdx + k), 32'd5, RespOkay, "threshold of 5");
      check_value(cfg_data_t'(pmu_irq[k]), 32'd0, "interrupt at zero count");
      for (i = 1; i <= 7; i++) begin
        llc_events[k] = 1'b1;
        next_cycle();
        llc_events = '0;
        read_expect(reg_addr(k), i, RespOkay, $sformatf("counter %0d step", k));
        check_value(cfg_data_t'(pmu_irq[k]), cfg_data_t'(i >= 5), "threshold interrupt");
      end
      write_expect(reg_addr(k), 32'hffff_ffff, RespOkay, "counter clear");
      read_expect(reg_addr(k), 32'd0, RespOkay, "counter after clear");
      check_value(cfg_data_t'(pmu_irq[k]), 32'd0, "interrupt after clear");
    end

    base = pulse_cnt;
    for (i = 0; i < 8; i++) begin
      dma_evt_valid = ~dma_evt_valid;
      repeat (3) next_cycle();
      check_value(cfg_data_t'(dma_evt_ack), cfg_data_t'(dma_evt_valid), "DMA event ack");
      repeat (3) next_cycle();
    end
    repeat (3) next_cycle();
    check_value(pulse_cnt - base, 32'd8, "DMA event pulse count");

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
src/host_pkg.sv
src/cfg_lite_fsm.sv
src/pmu_event_counters.sv
src/pmu_cfg_regs.sv
src/dma_evt_rx.sv
src/host_domain.sv
testbench/host_domain_sva.sv
testbench/tb_host_domain.sv

// File: Makefile
# Verilator build and run for the host domain testbench

VERILATOR ?= verilator
TOP       ?= tb_host_domain
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= SIMULATION FAILED
PASS_MSG  ?= SIMULATION PASSED
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
